/* hdl/cu_pkg.sv */
package cu_pkg;

	//////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////
	localparam int EDGE_SIZE             = 4;    // bytes per element
	localparam int CACHELINE_SIZE        = 64;   // bytes per line
	localparam int CACHELINE_EDGE_NUM    = CACHELINE_SIZE / EDGE_SIZE;
	localparam int EDGE_COUNT_BITS       = 16;
	localparam int ADDR_BITS             = 32;
	localparam int EDGE_FIFO_DEPTH       = 32;
	localparam int EDGE_FIFO_ALFULL_FREE = 4;    // free entries left when alfull rises
	localparam int EDGE_FIFO_PTR_BITS    = $clog2(EDGE_FIFO_DEPTH);

	localparam int EDGE_BITS        = EDGE_SIZE * 8;
	localparam int CACHELINE_BITS   = CACHELINE_SIZE * 8;
	localparam int EDGE_SHIFT       = $clog2(EDGE_SIZE);        // byte offset to element index
	localparam int LINE_OFFSET_BITS = $clog2(CACHELINE_SIZE);
	localparam int CL_IDX_BITS      = $clog2(CACHELINE_EDGE_NUM);
	localparam int CL_SIZE_BITS     = CL_IDX_BITS + 1;          // holds 0..16

	localparam logic [7:0] CU_ID = 8'd1;

	// which of the three edge arrays
	typedef enum logic [1:0] {
		ARRAY_SRC    = 2'd0,
		ARRAY_DEST   = 2'd1,
		ARRAY_WEIGHT = 2'd2
	} array_sel_t;

	//////////////////////////////////////////////////
	// job and descriptor structs
	//////////////////////////////////////////////////
	typedef struct packed {
		logic                       valid;
		logic [EDGE_COUNT_BITS-1:0] id;
		logic [EDGE_COUNT_BITS-1:0] inverse_edges_idx;   // first edge of the vertex
		logic [EDGE_COUNT_BITS-1:0] inverse_out_degree;
	} vertex_job_t;

	typedef struct packed {
		logic                 valid;
		logic [ADDR_BITS-1:0] src_base;
		logic [ADDR_BITS-1:0] dest_base;
		logic [ADDR_BITS-1:0] weight_base;
	} wed_t;

	typedef struct packed {
		logic                       valid;
		logic [EDGE_COUNT_BITS-1:0] id;
		logic [EDGE_BITS-1:0]       src;
		logic [EDGE_BITS-1:0]       dest;
		logic [EDGE_BITS-1:0]       weight;
	} edge_job_t;

	//////////////////////////////////////////////////
	// memory side
	//////////////////////////////////////////////////
	typedef struct packed {
		logic                    valid;
		array_sel_t              array;
		logic [ADDR_BITS-1:0]    address;            // line aligned
		logic [CL_IDX_BITS-1:0]  cacheline_offset;   // first element in the line
		logic [CL_SIZE_BITS-1:0] real_size;          // elements wanted
		logic [7:0]              cu_id;
	} read_cmd_t;

	typedef struct packed {
		logic                      valid;
		array_sel_t                array;
		logic [CL_IDX_BITS-1:0]    cacheline_offset;
		logic [CL_SIZE_BITS-1:0]   real_size;
		logic [CACHELINE_BITS-1:0] line;     // word k in bits [32k+31:32k]
	} read_resp_t;

	typedef struct packed {
		logic valid;    // head entry present
		logic empty;
		logic full;
		logic alfull;
	} buffer_status_t;

endpackage

/* hdl/sync_fifo.sv */
module sync_fifo
	import cu_pkg::*;
#(
	parameter type payload_t = logic
) (
	input  logic           clock,
	input  logic           rstn,
	input  logic           push,
	input  payload_t       data_in,
	input  logic           pop,
	output payload_t       data_out,
	output buffer_status_t status
);

	payload_t mem [EDGE_FIFO_DEPTH];

	logic [EDGE_FIFO_PTR_BITS-1:0] wr_ptr;
	logic [EDGE_FIFO_PTR_BITS-1:0] rd_ptr;
	logic [EDGE_FIFO_PTR_BITS:0]   count;
	logic                          fifo_empty;
	logic                          fifo_full;
	logic                          do_push;
	logic                          do_pop;

	assign fifo_empty = (count == '0);
	assign fifo_full  = (count == (EDGE_FIFO_PTR_BITS+1)'(EDGE_FIFO_DEPTH));
	assign do_push    = push && !fifo_full;
	assign do_pop     = pop && !fifo_empty;

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;    // depth is a power of two
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	// show-ahead head, zero while empty
	assign data_out = fifo_empty ? payload_t'('0) : mem[rd_ptr];

	always_comb begin
		status.valid  = !fifo_empty;
		status.empty  = fifo_empty;
		status.full   = fifo_full;
		status.alfull = (count >= (EDGE_FIFO_PTR_BITS+1)'(EDGE_FIFO_DEPTH - EDGE_FIFO_ALFULL_FREE));
	end

endmodule

/* hdl/cacheline_stream.sv */
module cacheline_stream
	import cu_pkg::*;
(
	input  logic                 clock,
	input  logic                 rstn,
	input  array_sel_t           array,
	input  read_resp_t           read_resp_in,
	input  logic                 shift,
	output logic [EDGE_BITS-1:0] element,
	output logic                 valid,
	output logic                 empty
);

	logic [CACHELINE_BITS-1:0] line_q;
	logic [CL_IDX_BITS-1:0]    idx_q;      // current element in the line
	logic [CL_SIZE_BITS-1:0]   count_q;    // elements still to hand out
	logic                      capture;

	// only responses tagged with this array
	assign capture = read_resp_in.valid && (read_resp_in.array == array);

	//////////////////////////////////////////////////
	// line storage
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (capture)
			line_q <= read_resp_in.line;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			idx_q   <= '0;
			count_q <= '0;
		end else if (capture) begin
			idx_q   <= read_resp_in.cacheline_offset;
			count_q <= read_resp_in.real_size;
		end else if (shift && valid) begin
			idx_q   <= idx_q + 1'b1;
			count_q <= count_q - 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// element out
	//////////////////////////////////////////////////
	assign valid   = |count_q;
	assign element = line_q[int'(idx_q) * EDGE_BITS +: EDGE_BITS];

	// a line landing this cycle still counts as busy
	assign empty = !valid && !capture;

endmodule

/* hdl/edge_assembler.sv */
module edge_assembler
	import cu_pkg::*;
(
	input  logic                       clock,
	input  logic                       rstn,
	input  logic [EDGE_BITS-1:0]       src_elem,
	input  logic [EDGE_BITS-1:0]       dest_elem,
	input  logic [EDGE_BITS-1:0]       weight_elem,
	input  logic                       src_valid,
	input  logic                       dest_valid,
	input  logic                       weight_valid,
	input  logic                       new_vertex,
	output logic                       shift,
	output edge_job_t                  edge_out,
	output logic [EDGE_COUNT_BITS-1:0] edge_count_pushed
);

	logic [EDGE_COUNT_BITS-1:0] id_next;    // runs across vertices
	logic [EDGE_COUNT_BITS-1:0] id_q;
	logic [EDGE_BITS-1:0]       src_q;
	logic [EDGE_BITS-1:0]       dest_q;
	logic [EDGE_BITS-1:0]       weight_q;
	logic                       edge_valid_q;
	logic                       new_vertex_q;
	logic                       vertex_start;

	assign shift        = src_valid && dest_valid && weight_valid;
	assign vertex_start = new_vertex && !new_vertex_q;    // rising edge of the active flag

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_valid_q <= 1'b0;
			id_next      <= '0;
			new_vertex_q <= 1'b0;
		end else begin
			edge_valid_q <= shift;
			new_vertex_q <= new_vertex;
			if (shift)
				id_next <= id_next + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (shift) begin
			id_q     <= id_next;
			src_q    <= src_elem;
			dest_q   <= dest_elem;
			weight_q <= weight_elem;
		end
	end

	always_comb begin
		edge_out.valid  = edge_valid_q;
		edge_out.id     = id_q;
		edge_out.src    = src_q;
		edge_out.dest   = dest_q;
		edge_out.weight = weight_q;
	end

	//////////////////////////////////////////////////
	// pushes for the current vertex
	//////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			edge_count_pushed <= '0;
		else if (vertex_start)
			edge_count_pushed <= EDGE_COUNT_BITS'(edge_valid_q);
		else if (edge_valid_q)
			edge_count_pushed <= edge_count_pushed + 1'b1;
	end

endmodule

/* hdl/edge_job_control.sv */
module edge_job_control
	import cu_pkg::*;
(
	input  logic           clock,
	input  logic           rstn,
	input  wed_t           wed_in,
	input  vertex_job_t    vertex_job_in,
	input  buffer_status_t read_status,
	input  logic           read_resp_valid,
	input  logic           streams_empty,
	input  logic           edge_alfull,
	output read_cmd_t      read_cmd_out,
	output vertex_job_t    vertex_latched
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_INIT,
		S_WAIT,
		S_SIZE,
		S_SEND_SRC,
		S_SEND_DEST,
		S_SEND_WEIGHT
	} state_t;

	state_t state;
	state_t next_state;

	logic [EDGE_COUNT_BITS-1:0] remaining;      // edges not yet requested
	logic [ADDR_BITS-1:0]       next_offset;    // byte offset of the next group
	logic [ADDR_BITS-1:0]       line_offset;
	logic [CL_IDX_BITS-1:0]     cl_offset;
	logic [CL_SIZE_BITS-1:0]    room;
	logic [CL_SIZE_BITS-1:0]    group_size;
	logic [EDGE_COUNT_BITS-1:0] remaining_after;
	logic [2:0]                 outstanding;    // at most three per group
	logic                       vertex_seen;
	logic                       accept;
	logic                       group_ready;
	logic                       issue;
	logic [ADDR_BITS-1:0]       array_base;
	array_sel_t                 array_next;

	//////////////////////////////////////////////////
	// group geometry
	//////////////////////////////////////////////////
	assign cl_offset   = next_offset[LINE_OFFSET_BITS-1:EDGE_SHIFT];
	assign line_offset = {next_offset[ADDR_BITS-1:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};
	assign room        = CL_SIZE_BITS'(CACHELINE_EDGE_NUM) - CL_SIZE_BITS'(cl_offset);
	assign group_size  = (remaining < EDGE_COUNT_BITS'(room)) ? CL_SIZE_BITS'(remaining) : room;

	assign remaining_after = remaining - EDGE_COUNT_BITS'(read_cmd_out.real_size);

	// new id only, and only once the last vertex has fully drained
	assign accept = (state == S_IDLE) && vertex_job_in.valid && wed_in.valid &&
		(!vertex_seen || (vertex_job_in.id != vertex_latched.id)) &&
		(outstanding == '0) && streams_empty;

	assign group_ready = (outstanding == '0) && streams_empty && !edge_alfull;

	assign issue = ((state == S_SEND_SRC) || (state == S_SEND_DEST) ||
		(state == S_SEND_WEIGHT)) && !read_status.alfull;

	always_comb begin
		case (state)
			S_SEND_SRC: begin
				array_base = wed_in.src_base;
				array_next = ARRAY_SRC;
			end
			S_SEND_DEST: begin
				array_base = wed_in.dest_base;
				array_next = ARRAY_DEST;
			end
			default: begin
				array_base = wed_in.weight_base;
				array_next = ARRAY_WEIGHT;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// fsm
	//////////////////////////////////////////////////
	always_comb begin
		next_state = state;
		case (state)
			S_IDLE:        if (accept) next_state = S_INIT;
			S_INIT: begin
				if (vertex_latched.inverse_out_degree == '0)
					next_state = S_IDLE;    // nothing to fetch
				else
					next_state = S_WAIT;
			end
			S_WAIT:        if (group_ready) next_state = S_SIZE;
			S_SIZE:        next_state = S_SEND_SRC;
			S_SEND_SRC:    if (issue) next_state = S_SEND_DEST;
			S_SEND_DEST:   if (issue) next_state = S_SEND_WEIGHT;
			S_SEND_WEIGHT: begin
				if (issue)
					next_state = (remaining_after == '0) ? S_IDLE : S_WAIT;
			end
			default:       next_state = S_IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state          <= S_IDLE;
			remaining      <= '0;
			next_offset    <= '0;
			vertex_latched <= '0;
			vertex_seen    <= 1'b0;
			read_cmd_out   <= '0;
		end else begin
			state              <= next_state;
			read_cmd_out.valid <= 1'b0;    // one cycle per command
			case (state)
				S_IDLE: begin
					if (accept) begin
						vertex_latched <= vertex_job_in;
						vertex_seen    <= 1'b1;
					end
				end
				S_INIT: begin
					remaining   <= vertex_latched.inverse_out_degree;
					next_offset <= ADDR_BITS'(vertex_latched.inverse_edges_idx) << EDGE_SHIFT;
					if (vertex_latched.inverse_out_degree == '0)
						vertex_latched.valid <= 1'b0;
				end
				S_SIZE: begin
					read_cmd_out.cacheline_offset <= cl_offset;
					read_cmd_out.real_size        <= group_size;
					read_cmd_out.cu_id            <= CU_ID;
				end
				S_SEND_SRC, S_SEND_DEST: begin
					if (issue) begin
						read_cmd_out.valid   <= 1'b1;
						read_cmd_out.array   <= array_next;
						read_cmd_out.address <= array_base + line_offset;
					end
				end
				S_SEND_WEIGHT: begin
					if (issue) begin
						read_cmd_out.valid   <= 1'b1;
						read_cmd_out.array   <= array_next;
						read_cmd_out.address <= array_base + line_offset;
						remaining            <= remaining_after;
						next_offset          <= next_offset +
							(ADDR_BITS'(read_cmd_out.real_size) << EDGE_SHIFT);
						if (remaining_after == '0)
							vertex_latched.valid <= 1'b0;    // last group sent
					end
				end
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// outstanding responses
	//////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			outstanding <= '0;
		end else begin
			case ({issue, read_resp_valid})
				2'b10:   outstanding <= outstanding + 3'd1;
				2'b01:   outstanding <= outstanding - 3'd1;
				default: ;    // both or neither
			endcase
		end
	end

endmodule

/* hdl/edge_fetch_unit.sv */
module edge_fetch_unit
	import cu_pkg::*;
(
	input  logic                       clock,
	input  logic                       rstn,
	input  wed_t                       wed_in,
	input  vertex_job_t                vertex_job_in,
	input  buffer_status_t             read_status,
	input  read_resp_t                 read_resp_in,
	input  logic                       edge_request,
	output read_cmd_t                  read_cmd_out,
	output edge_job_t                  edge_job_out,
	output buffer_status_t             edge_status,
	output logic [EDGE_COUNT_BITS-1:0] edge_count_pushed
);

	vertex_job_t          vertex_latched;
	edge_job_t            edge_pushed;
	logic [EDGE_BITS-1:0] src_elem;
	logic [EDGE_BITS-1:0] dest_elem;
	logic [EDGE_BITS-1:0] weight_elem;
	logic                 src_valid;
	logic                 dest_valid;
	logic                 weight_valid;
	logic                 src_empty;
	logic                 dest_empty;
	logic                 weight_empty;
	logic                 streams_empty;
	logic                 shift;

	assign streams_empty = src_empty && dest_empty && weight_empty;

	//////////////////////////////////////////////////
	// command side
	//////////////////////////////////////////////////
	edge_job_control edge_job_control_inst (
		.clock           (clock),
		.rstn            (rstn),
		.wed_in          (wed_in),
		.vertex_job_in   (vertex_job_in),
		.read_status     (read_status),
		.read_resp_valid (read_resp_in.valid),
		.streams_empty   (streams_empty),
		.edge_alfull     (edge_status.alfull),
		.read_cmd_out    (read_cmd_out),
		.vertex_latched  (vertex_latched)
	);

	//////////////////////////////////////////////////
	// one stream per array
	//////////////////////////////////////////////////
	cacheline_stream src_stream_inst (
		.clock        (clock),
		.rstn         (rstn),
		.array        (ARRAY_SRC),
		.read_resp_in (read_resp_in),
		.shift        (shift),
		.element      (src_elem),
		.valid        (src_valid),
		.empty        (src_empty)
	);

	cacheline_stream dest_stream_inst (
		.clock        (clock),
		.rstn         (rstn),
		.array        (ARRAY_DEST),
		.read_resp_in (read_resp_in),
		.shift        (shift),
		.element      (dest_elem),
		.valid        (dest_valid),
		.empty        (dest_empty)
	);

	cacheline_stream weight_stream_inst (
		.clock        (clock),
		.rstn         (rstn),
		.array        (ARRAY_WEIGHT),
		.read_resp_in (read_resp_in),
		.shift        (shift),
		.element      (weight_elem),
		.valid        (weight_valid),
		.empty        (weight_empty)
	);

	edge_assembler edge_assembler_inst (
		.clock             (clock),
		.rstn              (rstn),
		.src_elem          (src_elem),
		.dest_elem         (dest_elem),
		.weight_elem       (weight_elem),
		.src_valid         (src_valid),
		.dest_valid        (dest_valid),
		.weight_valid      (weight_valid),
		.new_vertex        (vertex_latched.valid),
		.shift             (shift),
		.edge_out          (edge_pushed),
		.edge_count_pushed (edge_count_pushed)
	);

	// edge job queue, popped by the consumer
	sync_fifo #(
		.payload_t (edge_job_t)
	) edge_fifo_inst (
		.clock    (clock),
		.rstn     (rstn),
		.push     (edge_pushed.valid),
		.data_in  (edge_pushed),
		.pop      (edge_request),
		.data_out (edge_job_out),
		.status   (edge_status)
	);

endmodule

/* verification/edge_mem_model.sv */
module edge_mem_model
	import cu_pkg::*;
(
	input  logic       clock,
	input  logic       rstn,
	input  wed_t       wed_in,
	input  read_cmd_t  read_cmd_in,
	output read_resp_t read_resp_out
);

	read_cmd_t  pend_cmd [$];    // commands waiting for their delay
	int         pend_due [$];
	int         ready [$];
	int         cycle = 0;
	int         pick;
	read_resp_t next_resp;
	read_resp_t resp_q = '0;

	assign read_resp_out = resp_q;

	// word k is array code * 2^28 plus the element index at address + 4k
	function automatic logic [CACHELINE_BITS-1:0] build_line(input read_cmd_t cmd);
		logic [CACHELINE_BITS-1:0] line;
		logic [ADDR_BITS-1:0]      base;
		logic [ADDR_BITS-1:0]      index;
		case (cmd.array)
			ARRAY_SRC:  base = wed_in.src_base;
			ARRAY_DEST: base = wed_in.dest_base;
			default:    base = wed_in.weight_base;
		endcase
		for (int k = 0; k < CACHELINE_EDGE_NUM; k++) begin
			index = (cmd.address + ADDR_BITS'(k * EDGE_SIZE) - base) >> EDGE_SHIFT;
			line[k*EDGE_BITS +: EDGE_BITS] = (ADDR_BITS'(cmd.array) << 28) + index;
		end
		return line;
	endfunction

	always @(negedge clock) begin
		if (rstn && read_cmd_in.valid) begin
			pend_cmd.push_back(read_cmd_in);
			pend_due.push_back(cycle + int'($urandom_range(1, 6)));
		end
	end

	//////////////////////////////////////////////////
	// one response per cycle, any due entry
	//////////////////////////////////////////////////
	always @(posedge clock) begin
		cycle = cycle + 1;
		if (!rstn) begin
			resp_q <= '0;
		end else begin
			ready.delete();
			foreach (pend_due[i])
				if (pend_due[i] <= cycle)
					ready.push_back(i);
			if (ready.size() > 0) begin
				pick = ready[$urandom_range(0, ready.size() - 1)];    // may reorder
				next_resp.valid            = 1'b1;
				next_resp.array            = pend_cmd[pick].array;
				next_resp.cacheline_offset = pend_cmd[pick].cacheline_offset;
				next_resp.real_size        = pend_cmd[pick].real_size;
				next_resp.line             = build_line(pend_cmd[pick]);
				pend_cmd.delete(pick);
				pend_due.delete(pick);
				resp_q <= next_resp;
			end else begin
				resp_q <= '0;
			end
		end
	end

endmodule

/* verification/edge_fetch_tb.sv */
module edge_fetch_tb
	import cu_pkg::*;
();

	typedef struct packed {
		logic [EDGE_COUNT_BITS-1:0] id;
		logic [EDGE_COUNT_BITS-1:0] idx;
		logic [EDGE_COUNT_BITS-1:0] degree;
		logic [7:0]                 alfull_pct;    // read alfull chance per cycle
		logic [7:0]                 pop_pct;
	} stim_row_t;

	localparam int                   NUM_ROWS    = 8;
	localparam int                   IDLE_WAIT   = 20;
	localparam logic [ADDR_BITS-1:0] SRC_BASE    = 32'h0010_0000;
	localparam logic [ADDR_BITS-1:0] DEST_BASE   = 32'h0020_0000;
	localparam logic [ADDR_BITS-1:0] WEIGHT_BASE = 32'h0030_0000;

	// drained edge FIFO
	localparam buffer_status_t IDLE_STATUS = '{valid: 1'b0, empty: 1'b1, full: 1'b0, alfull: 1'b0};

	logic                       clock;
	logic                       rstn = 1'b0;
	wed_t                       wed_in;
	vertex_job_t                vertex_job_in;
	buffer_status_t             read_status = '0;
	read_resp_t                 read_resp_in;
	logic                       edge_request = 1'b0;
	read_cmd_t                  read_cmd_out;
	edge_job_t                  edge_job_out;
	buffer_status_t             edge_status;
	logic [EDGE_COUNT_BITS-1:0] edge_count_pushed;

	stim_row_t                  rows [NUM_ROWS];
	read_cmd_t                  exp_cmds [$];
	edge_job_t                  exp_edges [$];
	logic [EDGE_COUNT_BITS-1:0] next_edge_id = '0;    // runs across vertices
	logic [EDGE_COUNT_BITS-1:0] last_id = '0;
	logic [EDGE_COUNT_BITS-1:0] last_count = '0;
	int                         checks = 0;
	int                         errors = 0;
	int                         cmds_seen;
	int                         edges_seen;
	int                         alfull_pct = 0;
	int                         pop_pct = 0;
	logic                       row_active = 1'b0;

	edge_fetch_unit edge_fetch_unit_inst (
		.clock             (clock),
		.rstn              (rstn),
		.wed_in            (wed_in),
		.vertex_job_in     (vertex_job_in),
		.read_status       (read_status),
		.read_resp_in      (read_resp_in),
		.edge_request      (edge_request),
		.read_cmd_out      (read_cmd_out),
		.edge_job_out      (edge_job_out),
		.edge_status       (edge_status),
		.edge_count_pushed (edge_count_pushed)
	);

	edge_mem_model edge_mem_model_inst (
		.clock         (clock),
		.rstn          (rstn),
		.wed_in        (wed_in),
		.read_cmd_in   (read_cmd_out),
		.read_resp_out (read_resp_in)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic load_table();
		//        id      idx        degree  alfull pop
		rows[0] = '{16'd1, 16'd0,    16'd40, 8'd0,  8'd100};    // aligned with full groups
		rows[1] = '{16'd2, 16'd37,   16'd30, 8'd0,  8'd100};    // starts at element 5
		rows[2] = '{16'd3, 16'd100,  16'd0,  8'd0,  8'd100};
		rows[3] = '{16'd3, 16'd200,  16'd25, 8'd0,  8'd100};    // same id again
		rows[4] = '{16'd4, 16'd64,   16'd16, 8'd30, 8'd70};
		rows[5] = '{16'd5, 16'd3,    16'd7,  8'd50, 8'd60};
		rows[6] = '{16'd6, 16'd500,  16'd50, 8'd40, 8'd60};
		rows[7] = '{16'd7, 16'd1023, 16'd33, 8'd20, 8'd80};     // one-element first group
	endtask

	function automatic int timeout_cycles();
		int total;
		total = 0;
		foreach (rows[r])
			total += int'(rows[r].degree);
		return total * 40 + 2000;
	endfunction

	function automatic logic [ADDR_BITS-1:0] array_base(input array_sel_t a);
		case (a)
			ARRAY_SRC:  return SRC_BASE;
			ARRAY_DEST: return DEST_BASE;
			default:    return WEIGHT_BASE;
		endcase
	endfunction

	function automatic logic [EDGE_BITS-1:0] expected_word(input array_sel_t a, input int index);
		return (EDGE_BITS'(a) << 28) + EDGE_BITS'(index);
	endfunction

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////
	task automatic check_cmd(input read_cmd_t got, input read_cmd_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: read_cmd_out got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic check_edge(input edge_job_t got, input edge_job_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: edge_job_out got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic check_count(input logic [EDGE_COUNT_BITS-1:0] got,
		input logic [EDGE_COUNT_BITS-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: edge_count_pushed got %0d expected %0d", $time, got, exp);
		end
	endtask

	task automatic check_status(input buffer_status_t got, input buffer_status_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: edge_status got %b expected %b", $time, got, exp);
		end
	endtask

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////
	task automatic queue_commands(input stim_row_t row);
		logic [ADDR_BITS-1:0] offset;
		read_cmd_t            cmd;
		int                   remaining;
		int                   cl_off;
		int                   grp_size;
		offset    = ADDR_BITS'(row.idx) * EDGE_SIZE;
		remaining = int'(row.degree);
		while (remaining > 0) begin
			cl_off   = int'(offset % CACHELINE_SIZE) / EDGE_SIZE;
			grp_size = CACHELINE_EDGE_NUM - cl_off;
			if (remaining < grp_size)
				grp_size = remaining;
			for (int a = 0; a < 3; a++) begin    // src, dest, weight
				cmd.valid            = 1'b1;
				cmd.array            = array_sel_t'(a);
				cmd.address          = array_base(cmd.array) + offset - (offset % CACHELINE_SIZE);
				cmd.cacheline_offset = CL_IDX_BITS'(cl_off);
				cmd.real_size        = CL_SIZE_BITS'(grp_size);
				cmd.cu_id            = CU_ID;
				exp_cmds.push_back(cmd);
			end
			offset    += ADDR_BITS'(grp_size * EDGE_SIZE);
			remaining -= grp_size;
		end
	endtask

	task automatic queue_edges(input stim_row_t row);
		edge_job_t e;
		for (int i = 0; i < int'(row.degree); i++) begin
			e.valid  = 1'b1;
			e.id     = next_edge_id;
			e.src    = expected_word(ARRAY_SRC, int'(row.idx) + i);
			e.dest   = expected_word(ARRAY_DEST, int'(row.idx) + i);
			e.weight = expected_word(ARRAY_WEIGHT, int'(row.idx) + i);
			exp_edges.push_back(e);
			next_edge_id++;
		end
	endtask

	// commands and popped edges sampled mid-cycle
	always @(negedge clock) begin
		if (rstn && read_cmd_out.valid) begin
			cmds_seen++;
			if (exp_cmds.size() == 0) begin
				errors++;
				$display("Unexpected read command at %0t to address %h", $time,
					read_cmd_out.address);
			end else begin
				check_cmd(read_cmd_out, exp_cmds.pop_front());
			end
		end
		if (rstn && edge_request && edge_status.valid) begin
			edges_seen++;
			if (exp_edges.size() == 0) begin
				errors++;
				$display("Unexpected edge popped at %0t with id %0d", $time, edge_job_out.id);
			end else begin
				check_edge(edge_job_out, exp_edges.pop_front());
			end
		end
	end

	always @(posedge clock) begin
		if (rstn) begin
			read_status.alfull <= ($urandom_range(0, 99) < alfull_pct);
			edge_request       <= row_active && ($urandom_range(0, 99) < pop_pct);
		end
	end

	task automatic run_row(input int r);
		stim_row_t                  row;
		logic                       repeated;
		logic [EDGE_COUNT_BITS-1:0] count_exp;
		int                         errors_before;
		row           = rows[r];
		repeated      = (r > 0) && (row.id == last_id);
		errors_before = errors;
		cmds_seen     = 0;
		edges_seen    = 0;
		count_exp     = repeated ? last_count : row.degree;
		if (!repeated) begin
			queue_commands(row);
			queue_edges(row);
		end
		@(posedge clock);
		vertex_job_in <= '{1'b1, row.id, row.idx, row.degree};
		alfull_pct    <= int'(row.alfull_pct);
		pop_pct       <= int'(row.pop_pct);
		row_active    <= 1'b1;
		if (repeated || row.degree == '0) begin
			repeat (IDLE_WAIT) @(negedge clock);
		end else begin
			while (edges_seen < int'(row.degree) || edge_count_pushed != row.degree)
				@(negedge clock);
		end
		@(posedge clock);
		row_active <= 1'b0;
		repeat (4) @(negedge clock);    // let stray commands show up
		if (exp_cmds.size() != 0 || exp_edges.size() != 0) begin
			errors++;
			$display("Row %0d ended with %0d commands and %0d edges never seen", r,
				exp_cmds.size(), exp_edges.size());
			exp_cmds.delete();
			exp_edges.delete();
		end
		check_count(edge_count_pushed, count_exp);
		check_status(edge_status, IDLE_STATUS);    // every edge of the row was popped
		last_id    = row.id;
		last_count = count_exp;
		$display("row %0d vertex %0d degree %0d: %0d commands, %0d edges, %s", r, row.id,
			row.degree, cmds_seen, edges_seen, (errors == errors_before) ? "ok" : "errors");
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////
	initial begin
		void'($urandom(32'hb103_1d6b));
		load_table();
		wed_in        = '0;
		vertex_job_in = '0;
		repeat (8) @(negedge clock);
		check_count(edge_count_pushed, '0);
		check_status(edge_status, IDLE_STATUS);
		if (read_cmd_out.valid || edge_job_out.valid) begin
			errors++;
			$display("Outputs not idle during reset at %0t", $time);
		end
		@(posedge clock);
		rstn   <= 1'b1;
		wed_in <= '{1'b1, SRC_BASE, DEST_BASE, WEIGHT_BASE};
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);
		$display("%0d rows run, %0d checks, %0d errors", NUM_ROWS, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		int limit;
		@(posedge rstn);
		limit = timeout_cycles();
		repeat (limit) @(posedge clock);
		$display("Watchdog expired after %0d cycles, edge fetch did not finish", limit);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* src.f */
hdl/cu_pkg.sv
hdl/sync_fifo.sv
hdl/cacheline_stream.sv
hdl/edge_assembler.sv
hdl/edge_job_control.sv
hdl/edge_fetch_unit.sv
verification/edge_mem_model.sv
verification/edge_fetch_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       := edge_fetch_tb
FILELIST  := src.f
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
